// ==== src/csr_pkg.sv ====
`default_nettype none

package csr_pkg;

    localparam int CSR_NUM_W = 14;
    localparam int DATA_W    = 32;
    localparam int ECODE_W   = 6;
    localparam int ESUB_W    = 9;
    localparam int INT_W     = 13;
    localparam int HW_INT_W  = 8;
    localparam int SW_INT_W  = 2;

    typedef logic [DATA_W-1:0] csr_word_t;

    typedef enum logic [CSR_NUM_W-1:0] {
        CSR_CRMD   = 14'h000,
        CSR_PRMD   = 14'h001,
        CSR_ECFG   = 14'h004,
        CSR_ESTAT  = 14'h005,
        CSR_ERA    = 14'h006,
        CSR_BADV   = 14'h007,
        CSR_EENTRY = 14'h00c,
        // SAVE n sits at SAVE0 plus n
        CSR_SAVE0  = 14'h030,
        CSR_TID    = 14'h040,
        CSR_TCFG   = 14'h041,
        CSR_TVAL   = 14'h042,
        CSR_TICLR  = 14'h044
    } csr_num_e;

    typedef enum logic [ECODE_W-1:0] {
        ECODE_INT = 6'h00,
        ECODE_ADE = 6'h08,
        ECODE_ALE = 6'h09,
        ECODE_SYS = 6'h0b,
        ECODE_BRK = 6'h0c,
        ECODE_INE = 6'h0d
    } ecode_e;

    // Fetch-side address error
    localparam logic [ESUB_W-1:0] ESUBCODE_ADEF = '0;

    // Bit 10 has no source
    localparam logic [INT_W-1:0] ECFG_LIE_MASK = 13'h1bff;

    localparam int CRMD_PLV_LSB     = 0;
    localparam int CRMD_PLV_MSB     = 1;
    localparam int CRMD_IE          = 2;
    localparam int CRMD_DA          = 3;
    localparam int PRMD_PPLV_LSB    = 0;
    localparam int PRMD_PPLV_MSB    = 1;
    localparam int PRMD_PIE         = 2;
    localparam int ESTAT_IS_LSB     = 0;
    localparam int ESTAT_IS_MSB     = 12;
    localparam int ESTAT_ECODE_LSB  = 16;
    localparam int ESTAT_ECODE_MSB  = 21;
    localparam int ESTAT_ESUB_LSB   = 22;
    localparam int ESTAT_ESUB_MSB   = 30;
    localparam int TCFG_EN          = 0;
    localparam int TCFG_PERIODIC    = 1;
    localparam int TCFG_INITVAL_LSB = 2;
    localparam int TCFG_INITVAL_MSB = 31;
    localparam int TICLR_CLR        = 0;
    localparam int EENTRY_VA_LSB    = 6;
    localparam int EENTRY_VA_MSB    = 31;

    localparam int HW_IRQ_LSB    = SW_INT_W;
    localparam int TIMER_IRQ_BIT = 11;
    localparam int IPI_IRQ_BIT   = 12;

    // New bits where the mask is set, old bits elsewhere
    function automatic csr_word_t csr_merge(input csr_word_t old_val,
                                            input csr_word_t wmask,
                                            input csr_word_t wvalue);
        return (wmask & wvalue) | (~wmask & old_val);
    endfunction

endpackage

`default_nettype wire

// ==== src/csr_access_if.sv ====
`default_nettype none

interface csr_access_if;
    import csr_pkg::*;

    csr_num_e  num;
    logic      we;
    csr_word_t wmask;
    csr_word_t wvalue;

    modport master (
        output num,
        output we,
        output wmask,
        output wvalue
    );

    modport target (
        input num,
        input we,
        input wmask,
        input wvalue
    );

endinterface

`default_nettype wire

// ==== src/csr_exc_regs.sv ====
`default_nettype none

module csr_exc_regs #(
    parameter int NUM_SAVE = 4
) (
    input  logic                                          clk,
    input  logic                                          resetn,
    csr_access_if.target                                  bus,
    input  logic                                          wb_ex,
    input  logic                                          ertn_flush,
    input  logic [csr_pkg::ECODE_W-1:0]                   wb_ecode,
    input  logic [csr_pkg::ESUB_W-1:0]                    wb_esubcode,
    input  csr_pkg::csr_word_t                            wb_pc,
    input  csr_pkg::csr_word_t                            wb_vaddr,
    input  csr_pkg::csr_word_t                            rdata_in,
    output csr_pkg::csr_word_t                            rdata_out,
    output logic                                          crmd_ie,
    output logic [csr_pkg::ECODE_W+csr_pkg::ESUB_W-1:0]   estat_code,
    output csr_pkg::csr_word_t                            ex_entry
);
    import csr_pkg::*;

    logic [CRMD_PLV_MSB:CRMD_PLV_LSB]      crmd_plv;
    logic [PRMD_PPLV_MSB:PRMD_PPLV_LSB]    prmd_pplv;
    logic                                  prmd_pie;
    logic [ECODE_W-1:0]                    estat_ecode;
    logic [ESUB_W-1:0]                     estat_esubcode;
    csr_word_t                             era;
    csr_word_t                             badv;
    logic [EENTRY_VA_MSB-EENTRY_VA_LSB:0]  eentry_va;
    csr_word_t                             save_q [NUM_SAVE];

    csr_word_t crmd_rvalue;
    csr_word_t prmd_rvalue;
    csr_word_t eentry_rvalue;
    csr_word_t save_rvalue;
    csr_word_t sel_rvalue;
    csr_word_t crmd_wdata;
    csr_word_t prmd_wdata;
    csr_word_t eentry_wdata;

    logic wr_crmd;
    logic wr_prmd;
    logic wr_era;
    logic wr_badv;
    logic wr_eentry;
    logic addr_err;
    logic badv_from_pc;

    assign wr_crmd   = bus.we && (bus.num == CSR_CRMD);
    assign wr_prmd   = bus.we && (bus.num == CSR_PRMD);
    assign wr_era    = bus.we && (bus.num == CSR_ERA);
    assign wr_badv   = bus.we && (bus.num == CSR_BADV);
    assign wr_eentry = bus.we && (bus.num == CSR_EENTRY);

    // Only ADE and ALE report a bad address
    assign addr_err     = (wb_ecode == ECODE_ADE) || (wb_ecode == ECODE_ALE);
    assign badv_from_pc = (wb_ecode == ECODE_ADE) && (wb_esubcode == ESUBCODE_ADEF);

    always_comb begin
        crmd_rvalue = '0;
        crmd_rvalue[CRMD_PLV_MSB:CRMD_PLV_LSB] = crmd_plv;
        crmd_rvalue[CRMD_IE] = crmd_ie;
        // DA stays set with no translation
        crmd_rvalue[CRMD_DA] = 1'b1;

        prmd_rvalue = '0;
        prmd_rvalue[PRMD_PPLV_MSB:PRMD_PPLV_LSB] = prmd_pplv;
        prmd_rvalue[PRMD_PIE] = prmd_pie;

        eentry_rvalue = '0;
        eentry_rvalue[EENTRY_VA_MSB:EENTRY_VA_LSB] = eentry_va;
    end

    assign crmd_wdata   = csr_merge(crmd_rvalue, bus.wmask, bus.wvalue);
    assign prmd_wdata   = csr_merge(prmd_rvalue, bus.wmask, bus.wvalue);
    assign eentry_wdata = csr_merge(eentry_rvalue, bus.wmask, bus.wvalue);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            crmd_plv <= '0;
            crmd_ie  <= 1'b0;
        end else if (wb_ex) begin
            crmd_plv <= '0;
            crmd_ie  <= 1'b0;
        end else if (ertn_flush) begin
            crmd_plv <= prmd_pplv;
            crmd_ie  <= prmd_pie;
        end else if (wr_crmd) begin
            crmd_plv <= crmd_wdata[CRMD_PLV_MSB:CRMD_PLV_LSB];
            crmd_ie  <= crmd_wdata[CRMD_IE];
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            prmd_pplv <= '0;
            prmd_pie  <= 1'b0;
        end else if (wb_ex) begin
            prmd_pplv <= crmd_plv;
            prmd_pie  <= crmd_ie;
        end else if (wr_prmd) begin
            prmd_pplv <= prmd_wdata[PRMD_PPLV_MSB:PRMD_PPLV_LSB];
            prmd_pie  <= prmd_wdata[PRMD_PIE];
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            estat_ecode    <= '0;
            estat_esubcode <= '0;
            era            <= '0;
            badv           <= '0;
        end else if (wb_ex) begin
            estat_ecode    <= wb_ecode;
            estat_esubcode <= wb_esubcode;
            era            <= wb_pc;
            if (addr_err) begin
                badv <= badv_from_pc ? wb_pc : wb_vaddr;
            end
        end else begin
            if (wr_era) begin
                era <= csr_merge(era, bus.wmask, bus.wvalue);
            end
            if (wr_badv) begin
                badv <= csr_merge(badv, bus.wmask, bus.wvalue);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            eentry_va <= '0;
        end else if (wr_eentry) begin
            eentry_va <= eentry_wdata[EENTRY_VA_MSB:EENTRY_VA_LSB];
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            for (int i = 0; i < NUM_SAVE; i++) begin
                save_q[i] <= '0;
            end
        end else begin
            for (int i = 0; i < NUM_SAVE; i++) begin
                if (bus.we && (bus.num == CSR_SAVE0 + i)) begin
                    save_q[i] <= csr_merge(save_q[i], bus.wmask, bus.wvalue);
                end
            end
        end
    end

    always_comb begin
        save_rvalue = '0;
        for (int i = 0; i < NUM_SAVE; i++) begin
            if (bus.num == CSR_SAVE0 + i) begin
                save_rvalue = save_q[i];
            end
        end
    end

    always_comb begin
        case (bus.num)
            CSR_CRMD:   sel_rvalue = crmd_rvalue;
            CSR_PRMD:   sel_rvalue = prmd_rvalue;
            CSR_ERA:    sel_rvalue = era;
            CSR_BADV:   sel_rvalue = badv;
            CSR_EENTRY: sel_rvalue = eentry_rvalue;
            default:    sel_rvalue = save_rvalue;
        endcase
    end

    assign rdata_out  = rdata_in | sel_rvalue;
    assign estat_code = {estat_esubcode, estat_ecode};
    assign ex_entry   = eentry_rvalue;

endmodule

`default_nettype wire

// ==== src/csr_int_ctrl.sv ====
`default_nettype none

module csr_int_ctrl (
    input  logic                                          clk,
    input  logic                                          resetn,
    csr_access_if.target                                  bus,
    input  logic [csr_pkg::HW_INT_W-1:0]                  hw_int,
    input  logic                                          ipi_int,
    input  logic                                          timer_int,
    input  logic                                          crmd_ie,
    input  logic [csr_pkg::ECODE_W+csr_pkg::ESUB_W-1:0]   estat_code,
    input  csr_pkg::csr_word_t                            rdata_in,
    output csr_pkg::csr_word_t                            rdata_out,
    output logic                                          has_int
);
    import csr_pkg::*;

    logic [SW_INT_W-1:0] is_sw;
    logic [HW_INT_W-1:0] hw_int_q;
    logic                ipi_int_q;
    logic [INT_W-1:0]    ecfg_lie;
    logic [INT_W-1:0]    is_vec;

    csr_word_t estat_rvalue;
    csr_word_t ecfg_rvalue;
    csr_word_t estat_wdata;
    csr_word_t ecfg_wdata;
    csr_word_t sel_rvalue;

    logic wr_estat;
    logic wr_ecfg;

    assign wr_estat = bus.we && (bus.num == CSR_ESTAT);
    assign wr_ecfg  = bus.we && (bus.num == CSR_ECFG);

    always_comb begin
        is_vec = '0;
        is_vec[SW_INT_W-1:0] = is_sw;
        is_vec[HW_IRQ_LSB +: HW_INT_W] = hw_int_q;
        is_vec[TIMER_IRQ_BIT] = timer_int;
        is_vec[IPI_IRQ_BIT] = ipi_int_q;

        estat_rvalue = '0;
        estat_rvalue[ESTAT_IS_MSB:ESTAT_IS_LSB] = is_vec;
        estat_rvalue[ESTAT_ECODE_MSB:ESTAT_ECODE_LSB] = estat_code[ECODE_W-1:0];
        estat_rvalue[ESTAT_ESUB_MSB:ESTAT_ESUB_LSB] = estat_code[ECODE_W +: ESUB_W];

        ecfg_rvalue = '0;
        ecfg_rvalue[INT_W-1:0] = ecfg_lie;
    end

    assign estat_wdata = csr_merge(estat_rvalue, bus.wmask, bus.wvalue);
    assign ecfg_wdata  = csr_merge(ecfg_rvalue, bus.wmask, bus.wvalue);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            is_sw     <= '0;
            hw_int_q  <= '0;
            ipi_int_q <= 1'b0;
            ecfg_lie  <= '0;
        end else begin
            // External lines land one cycle late
            hw_int_q  <= hw_int;
            ipi_int_q <= ipi_int;
            if (wr_estat) begin
                is_sw <= estat_wdata[SW_INT_W-1:0];
            end
            if (wr_ecfg) begin
                ecfg_lie <= ecfg_wdata[INT_W-1:0] & ECFG_LIE_MASK;
            end
        end
    end

    always_comb begin
        case (bus.num)
            CSR_ESTAT: sel_rvalue = estat_rvalue;
            CSR_ECFG:  sel_rvalue = ecfg_rvalue;
            default:   sel_rvalue = '0;
        endcase
    end

    assign rdata_out = rdata_in | sel_rvalue;
    assign has_int   = (|(is_vec & ecfg_lie)) && crmd_ie;

endmodule

`default_nettype wire

// ==== src/csr_timer.sv ====
`default_nettype none

module csr_timer (
    input  logic                clk,
    input  logic                resetn,
    csr_access_if.target        bus,
    input  csr_pkg::csr_word_t  coreid,
    input  csr_pkg::csr_word_t  rdata_in,
    output csr_pkg::csr_word_t  rdata_out,
    output logic                timer_int
);
    import csr_pkg::*;

    csr_word_t                                   tid;
    logic                                        tcfg_en;
    logic                                        tcfg_periodic;
    logic [TCFG_INITVAL_MSB-TCFG_INITVAL_LSB:0]  tcfg_initval;
    csr_word_t                                   timer_cnt;

    csr_word_t tcfg_rvalue;
    csr_word_t tcfg_next;
    csr_word_t sel_rvalue;

    logic wr_tid;
    logic wr_tcfg;
    logic ticlr_clr;
    logic cnt_zero;

    assign wr_tid  = bus.we && (bus.num == CSR_TID);
    assign wr_tcfg = bus.we && (bus.num == CSR_TCFG);
    assign ticlr_clr = bus.we && (bus.num == CSR_TICLR)
                    && bus.wmask[TICLR_CLR] && bus.wvalue[TICLR_CLR];

    always_comb begin
        tcfg_rvalue = '0;
        tcfg_rvalue[TCFG_EN] = tcfg_en;
        tcfg_rvalue[TCFG_PERIODIC] = tcfg_periodic;
        tcfg_rvalue[TCFG_INITVAL_MSB:TCFG_INITVAL_LSB] = tcfg_initval;
    end

    // Value TCFG takes after this cycle's write
    assign tcfg_next = csr_merge(tcfg_rvalue, bus.wmask, bus.wvalue);
    assign cnt_zero  = (timer_cnt == '0);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            tid           <= coreid;
            tcfg_en       <= 1'b0;
            tcfg_periodic <= 1'b0;
            tcfg_initval  <= '0;
        end else begin
            if (wr_tid) begin
                tid <= csr_merge(tid, bus.wmask, bus.wvalue);
            end
            if (wr_tcfg) begin
                tcfg_en       <= tcfg_next[TCFG_EN];
                tcfg_periodic <= tcfg_next[TCFG_PERIODIC];
                tcfg_initval  <= tcfg_next[TCFG_INITVAL_MSB:TCFG_INITVAL_LSB];
            end
        end
    end

    // Down-counter parks at all ones once a one-shot expires
    always_ff @(posedge clk) begin
        if (!resetn) begin
            timer_cnt <= '1;
        end else if (wr_tcfg && tcfg_next[TCFG_EN]) begin
            timer_cnt <= {tcfg_next[TCFG_INITVAL_MSB:TCFG_INITVAL_LSB], 2'b00};
        end else if (tcfg_en && (timer_cnt != '1)) begin
            if (cnt_zero && tcfg_periodic) begin
                timer_cnt <= {tcfg_initval, 2'b00};
            end else begin
                timer_cnt <= timer_cnt - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            timer_int <= 1'b0;
        end else if (tcfg_en && cnt_zero) begin
            timer_int <= 1'b1;
        end else if (ticlr_clr) begin
            timer_int <= 1'b0;
        end
    end

    always_comb begin
        case (bus.num)
            CSR_TID:   sel_rvalue = tid;
            CSR_TCFG:  sel_rvalue = tcfg_rvalue;
            CSR_TVAL:  sel_rvalue = timer_cnt;
            default:   sel_rvalue = '0;
        endcase
    end

    assign rdata_out = rdata_in | sel_rvalue;

endmodule

`default_nettype wire

// ==== src/csr_unit.sv ====
`default_nettype none

module csr_unit #(
    parameter int NUM_SAVE = 4
) (
    input  logic                            clk,
    input  logic                            resetn,
    input  logic [csr_pkg::CSR_NUM_W-1:0]   csr_num,
    input  logic                            csr_we,
    input  csr_pkg::csr_word_t              csr_wmask,
    input  csr_pkg::csr_word_t              csr_wvalue,
    output csr_pkg::csr_word_t              csr_rvalue,
    input  logic                            wb_ex,
    input  logic                            ertn_flush,
    input  logic [csr_pkg::ECODE_W-1:0]     wb_ecode,
    input  logic [csr_pkg::ESUB_W-1:0]      wb_esubcode,
    input  csr_pkg::csr_word_t              wb_pc,
    input  csr_pkg::csr_word_t              wb_vaddr,
    input  logic [csr_pkg::HW_INT_W-1:0]    hw_int,
    input  logic                            ipi_int,
    input  csr_pkg::csr_word_t              coreid,
    output csr_pkg::csr_word_t              ex_entry,
    output logic                            has_int
);
    import csr_pkg::*;

    csr_word_t                   rdata_exc;
    csr_word_t                   rdata_int;
    logic                        crmd_ie;
    logic                        timer_int;
    logic [ECODE_W+ESUB_W-1:0]   estat_code;

    csr_access_if bus_if ();

    assign bus_if.num    = csr_num_e'(csr_num);
    assign bus_if.we     = csr_we;
    assign bus_if.wmask  = csr_wmask;
    assign bus_if.wvalue = csr_wvalue;

    csr_exc_regs #(
        .NUM_SAVE (NUM_SAVE)
    ) exc_regs_i (
        .clk         (clk),
        .resetn      (resetn),
        .bus         (bus_if.target),
        .wb_ex       (wb_ex),
        .ertn_flush  (ertn_flush),
        .wb_ecode    (wb_ecode),
        .wb_esubcode (wb_esubcode),
        .wb_pc       (wb_pc),
        .wb_vaddr    (wb_vaddr),
        .rdata_in    ('0),
        .rdata_out   (rdata_exc),
        .crmd_ie     (crmd_ie),
        .estat_code  (estat_code),
        .ex_entry    (ex_entry)
    );

    csr_int_ctrl int_ctrl_i (
        .clk        (clk),
        .resetn     (resetn),
        .bus        (bus_if.target),
        .hw_int     (hw_int),
        .ipi_int    (ipi_int),
        .timer_int  (timer_int),
        .crmd_ie    (crmd_ie),
        .estat_code (estat_code),
        .rdata_in   (rdata_exc),
        .rdata_out  (rdata_int),
        .has_int    (has_int)
    );

    csr_timer timer_i (
        .clk       (clk),
        .resetn    (resetn),
        .bus       (bus_if.target),
        .coreid    (coreid),
        .rdata_in  (rdata_int),
        .rdata_out (csr_rvalue),
        .timer_int (timer_int)
    );

endmodule

`default_nettype wire

// ==== sim/csr_clk_gen.sv ====
`default_nettype none

module csr_clk_gen #(
    parameter int HALF_PERIOD  = 4,
    parameter int RESET_CYCLES = 4
) (
    output logic clk,
    output logic resetn
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    // Release on a falling edge away from the sampling edge
    initial begin
        resetn = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        resetn = 1'b1;
    end

endmodule

`default_nettype wire

// ==== sim/csr_unit_tb.sv ====
`default_nettype none

module csr_unit_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import csr_pkg::*;

    localparam int        SAVE_COUNT = 4;
    localparam csr_word_t CORE_ID    = 32'h0000_0003;

    logic                 clk;
    logic                 resetn;
    logic [CSR_NUM_W-1:0] csr_num;
    logic                 csr_we;
    csr_word_t            csr_wmask;
    csr_word_t            csr_wvalue;
    csr_word_t            csr_rvalue;
    logic                 wb_ex;
    logic                 ertn_flush;
    logic [ECODE_W-1:0]   wb_ecode;
    logic [ESUB_W-1:0]    wb_esubcode;
    csr_word_t            wb_pc;
    csr_word_t            wb_vaddr;
    logic [HW_INT_W-1:0]  hw_int;
    logic                 ipi_int;
    csr_word_t            coreid;
    csr_word_t            ex_entry;
    logic                 has_int;

    int        error_count;
    int        check_count;
    logic [31:0] rand_state;

    csr_clk_gen #(.HALF_PERIOD(4), .RESET_CYCLES(4)) clk_gen_i (.clk(clk), .resetn(resetn));

    csr_unit #(.NUM_SAVE(SAVE_COUNT)) csr_unit_i (
        .clk(clk), .resetn(resetn),
        .csr_num(csr_num), .csr_we(csr_we), .csr_wmask(csr_wmask),
        .csr_wvalue(csr_wvalue), .csr_rvalue(csr_rvalue),
        .wb_ex(wb_ex), .ertn_flush(ertn_flush), .wb_ecode(wb_ecode),
        .wb_esubcode(wb_esubcode), .wb_pc(wb_pc), .wb_vaddr(wb_vaddr),
        .hw_int(hw_int), .ipi_int(ipi_int), .coreid(coreid),
        .ex_entry(ex_entry), .has_int(has_int)
    );

    function automatic logic [31:0] next_random();
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        return rand_state;
    endfunction

    task automatic check_word(input string what, input csr_word_t got, input csr_word_t exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("FAIL %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("FAIL %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic write_csr(input logic [CSR_NUM_W-1:0] num, input csr_word_t mask,
                             input csr_word_t value);
        @(negedge clk);
        csr_num    = num;
        csr_we     = 1'b1;
        csr_wmask  = mask;
        csr_wvalue = value;
        @(negedge clk);
        csr_we = 1'b0;
    endtask

    // Combinational read sampled mid low phase
    task automatic read_csr(input logic [CSR_NUM_W-1:0] num, output csr_word_t value);
        @(negedge clk);
        csr_num = num;
        csr_we  = 1'b0;
        #1;
        value = csr_rvalue;
    endtask

    task automatic expect_csr(input string what, input logic [CSR_NUM_W-1:0] num,
                              input csr_word_t exp);
        csr_word_t value;
        read_csr(num, value);
        check_word(what, value, exp);
    endtask

    task automatic pulse_exception(input logic [ECODE_W-1:0] ecode,
                                   input logic [ESUB_W-1:0] esub, input csr_word_t pc,
                                   input csr_word_t vaddr, input logic with_ertn);
        @(negedge clk);
        wb_ex       = 1'b1;
        ertn_flush  = with_ertn;
        wb_ecode    = ecode;
        wb_esubcode = esub;
        wb_pc       = pc;
        wb_vaddr    = vaddr;
        @(negedge clk);
        wb_ex      = 1'b0;
        ertn_flush = 1'b0;
    endtask

    task automatic pulse_ertn();
        @(negedge clk);
        ertn_flush = 1'b1;
        @(negedge clk);
        ertn_flush = 1'b0;
    endtask

    task automatic wait_has_int(input logic level, input int limit);
        int waited;
        waited = 0;
        while (has_int !== level && waited < limit) begin
            @(negedge clk);
            waited++;
        end
        check_count++;
        if (has_int !== level) begin
            error_count++;
            $display("Timed out after %0d cycles waiting for has_int to go %b", limit, level);
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        $display("Test %s finished with %0d errors", name, error_count - errors_before);
    endtask

    task automatic test_reset_and_writes();
        int                   start;
        csr_word_t            model [SAVE_COUNT+1];
        csr_word_t            mask;
        csr_word_t            value;
        logic [CSR_NUM_W-1:0] num;
        start = error_count;
        expect_csr("CRMD after reset", CSR_CRMD, 32'h0000_0008);
        expect_csr("TID after reset", CSR_TID, CORE_ID);
        for (int r = 0; r <= SAVE_COUNT; r++) begin
            model[r] = '0;
        end
        for (int round = 0; round < 2; round++) begin
            for (int r = 0; r <= SAVE_COUNT; r++) begin
                num   = (r == SAVE_COUNT) ? CSR_ERA : CSR_NUM_W'(CSR_SAVE0 + r);
                mask  = next_random();
                value = next_random();
                write_csr(num, mask, value);
                model[r] = (mask & value) | (~mask & model[r]);
                expect_csr($sformatf("CSR %h after masked write", num), num, model[r]);
            end
        end
        write_csr(CSR_EENTRY, '1, 32'hffff_ffff);
        expect_csr("EENTRY", CSR_EENTRY, 32'hffff_ffc0);
        check_word("ex_entry", ex_entry, 32'hffff_ffc0);
        expect_csr("unimplemented CSR", 14'h3ff, '0);
        report_test("reset_and_writes", start);
    endtask

    task automatic test_exception_entry();
        int start;
        start = error_count;
        write_csr(CSR_CRMD, 32'h7, 32'h7);
        expect_csr("CRMD before exception", CSR_CRMD, 32'h0000_000f);
        pulse_exception(ECODE_ADE, ESUBCODE_ADEF, 32'h1c00_0100, 32'hdead_0000, 1'b0);
        expect_csr("CRMD after ADE", CSR_CRMD, 32'h0000_0008);
        expect_csr("PRMD after ADE", CSR_PRMD, 32'h0000_0007);
        expect_csr("ERA after ADE", CSR_ERA, 32'h1c00_0100);
        expect_csr("BADV after ADE", CSR_BADV, 32'h1c00_0100);
        expect_csr("ESTAT after ADE", CSR_ESTAT, 32'h0008_0000);
        // Subcode 1 lands at ESTAT bit 22
        pulse_exception(ECODE_ALE, 9'h1, 32'h1c00_0200, 32'h0000_1233, 1'b0);
        expect_csr("ERA after ALE", CSR_ERA, 32'h1c00_0200);
        expect_csr("BADV after ALE", CSR_BADV, 32'h0000_1233);
        expect_csr("ESTAT after ALE", CSR_ESTAT, 32'h0049_0000);
        report_test("exception_entry", start);
    endtask

    task automatic test_exception_return();
        int start;
        start = error_count;
        write_csr(CSR_PRMD, '1, 32'h0000_0006);
        pulse_ertn();
        expect_csr("CRMD after return", CSR_CRMD, 32'h0000_000e);
        write_csr(CSR_CRMD, 32'h7, 32'h5);
        // Exception wins over a simultaneous return
        pulse_exception(ECODE_SYS, 9'h0, 32'h1c00_0300, 32'h0, 1'b1);
        expect_csr("CRMD after ex and ertn", CSR_CRMD, 32'h0000_0008);
        expect_csr("PRMD after ex and ertn", CSR_PRMD, 32'h0000_0005);
        expect_csr("ESTAT after ex and ertn", CSR_ESTAT, 32'h000b_0000);
        report_test("exception_return", start);
    endtask

    task automatic test_interrupts();
        int        start;
        csr_word_t value;
        start = error_count;
        write_csr(CSR_ECFG, '1, 32'hffff_ffff);
        expect_csr("ECFG all ones", CSR_ECFG, 32'h0000_1bff);
        write_csr(CSR_ECFG, '1, 32'h0000_0001);
        write_csr(CSR_ESTAT, 32'h3, 32'h1);
        check_flag("has_int with IE clear", has_int, 1'b0);
        write_csr(CSR_CRMD, 32'h4, 32'h4);
        wait_has_int(1'b1, 5);
        write_csr(CSR_ESTAT, 32'h3, 32'h0);
        wait_has_int(1'b0, 5);
        write_csr(CSR_ECFG, '1, 32'h0000_1bff);
        @(negedge clk);
        hw_int = 8'h08;
        wait_has_int(1'b1, 5);
        read_csr(CSR_ESTAT, value);
        check_word("ESTAT.IS with hw_int", value & 32'h1fff, 32'h0000_0020);
        @(negedge clk);
        hw_int = '0;
        wait_has_int(1'b0, 5);
        @(negedge clk);
        ipi_int = 1'b1;
        wait_has_int(1'b1, 5);
        read_csr(CSR_ESTAT, value);
        check_word("ESTAT.IS with ipi_int", value & 32'h1fff, 32'h0000_1000);
        write_csr(CSR_ECFG, '1, 32'h0);
        wait_has_int(1'b0, 5);
        @(negedge clk);
        ipi_int = 1'b0;
        report_test("interrupts", start);
    endtask

    task automatic test_timer();
        int        start;
        csr_word_t value;
        start = error_count;
        write_csr(CSR_ECFG, '1, 32'h0000_0800);
        // One-shot with INITVAL 8 loads 32
        write_csr(CSR_TCFG, '1, 32'h0000_0021);
        @(negedge clk);
        read_csr(CSR_TVAL, value);
        check_flag("TVAL below loaded value", value < 32'd32, 1'b1);
        wait_has_int(1'b1, 60);
        expect_csr("TVAL after one-shot", CSR_TVAL, 32'hffff_ffff);
        expect_csr("TICLR read", CSR_TICLR, '0);
        write_csr(CSR_TICLR, 32'h1, 32'h1);
        wait_has_int(1'b0, 5);
        write_csr(CSR_TCFG, '1, 32'h0000_0013);
        wait_has_int(1'b1, 40);
        write_csr(CSR_TICLR, 32'h1, 32'h1);
        wait_has_int(1'b0, 5);
        wait_has_int(1'b1, 40);
        write_csr(CSR_TCFG, '1, 32'h0);
        write_csr(CSR_TICLR, 32'h1, 32'h1);
        wait_has_int(1'b0, 5);
        report_test("timer", start);
    endtask

    initial begin
        int waited;
        csr_num     = '0;
        csr_we      = 1'b0;
        csr_wmask   = '0;
        csr_wvalue  = '0;
        wb_ex       = 1'b0;
        ertn_flush  = 1'b0;
        wb_ecode    = '0;
        wb_esubcode = '0;
        wb_pc       = '0;
        wb_vaddr    = '0;
        hw_int      = '0;
        ipi_int     = 1'b0;
        coreid      = CORE_ID;
        error_count = 0;
        check_count = 0;
        rand_state  = 32'd32;
        waited      = 0;
        while (resetn !== 1'b1 && waited < 20) begin
            @(negedge clk);
            waited++;
        end
        if (resetn !== 1'b1) begin
            error_count++;
            $display("Reset was never released");
        end
        test_reset_and_writes();
        test_exception_entry();
        test_exception_return();
        test_interrupts();
        test_timer();
        $display("Checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
src/csr_pkg.sv
src/csr_access_if.sv
src/csr_exc_regs.sv
src/csr_int_ctrl.sv
src/csr_timer.sv
src/csr_unit.sv
sim/csr_clk_gen.sv
sim/csr_unit_tb.sv

// ==== Bender.yml ====
package:
  name: csr_unit

sources:
  - src/csr_pkg.sv
  - src/csr_access_if.sv
  - src/csr_exc_regs.sv
  - src/csr_int_ctrl.sv
  - src/csr_timer.sv
  - src/csr_unit.sv
  - target: simulation
    files:
      - sim/csr_clk_gen.sv
      - sim/csr_unit_tb.sv
